// File: source/jtagUart_macros.svh
`ifndef JTAG_UART_MACROS_SVH
`define JTAG_UART_MACROS_SVH

// Byte lane carried through the bridge
`define JU_DATA_WIDTH 8

// Entries per FIFO, power of two
`define JU_FIFO_DEPTH 256

// Holds 0 through JU_FIFO_DEPTH
`define JU_COUNT_WIDTH 9

`endif

// File: source/jtagUartPkg.sv
`include "jtagUart_macros.svh"

package jtagUartPkg;

	// Virtual JTAG instruction register codes
	typedef enum logic [1:0] {
		irWriteData = 2'd0,
		irReadSpace = 2'd1,
		irReadData  = 2'd2,
		irReadCount = 2'd3
	} irCode_e;

	// Decoded DR state of the scan chain for one tck
	typedef struct packed {
		logic    sdr;
		logic    cdr;
		irCode_e ir;
		logic    tdi;
	} scanCtrl_t;

	// Memory-mapped slave request
	typedef struct packed {
		logic        read;
		logic        write;
		logic        address;
		logic [31:0] writeData;
	} busReq_t;

	// Occupancy of one byte FIFO
	typedef struct packed {
		logic                       empty;
		logic                       full;
		logic [`JU_COUNT_WIDTH-1:0] count;
	} fifoStatus_t;

endpackage

// File: source/byteFifo.sv
`timescale 1ns/1ps
`include "jtagUart_macros.svh"

module byteFifo #(
	parameter int Depth = `JU_FIFO_DEPTH
) (
	input  logic                        tck,
	input  logic                        reset_n,
	input  logic                        push,
	input  logic [`JU_DATA_WIDTH-1:0]   pushByte,
	input  logic                        pop,
	output logic [`JU_DATA_WIDTH-1:0]   headByte,
	output jtagUartPkg::fifoStatus_t    status
);

	localparam int PtrWidth = $clog2(Depth);

	logic [`JU_DATA_WIDTH-1:0] mem [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [`JU_COUNT_WIDTH-1:0] count;
	logic empty;
	logic full;
	logic doPush;
	logic doPop;

	assign empty = count == '0;
	assign full = count == `JU_COUNT_WIDTH'(Depth);

	// Overflow and underflow are dropped here, senders never look at the flags
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	always_ff @(posedge tck or negedge reset_n) begin
		if (!reset_n) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + PtrWidth'(1);
			if (doPop)
				rdPtr <= rdPtr + PtrWidth'(1);
			case ({doPush, doPop})
				2'b10:   count <= count + `JU_COUNT_WIDTH'(1);
				2'b01:   count <= count - `JU_COUNT_WIDTH'(1);
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge tck) begin
		if (doPush)
			mem[wrPtr] <= pushByte;
	end

	// Show-ahead head, forced to zero while nothing is stored
	assign headByte = empty ? '0 : mem[rdPtr];

	assign status.empty = empty;
	assign status.full = full;
	assign status.count = count;

endmodule

// File: source/jtagDrShifter.sv
`timescale 1ns/1ps
`include "jtagUart_macros.svh"

module jtagDrShifter (
	input  logic                        tck,
	input  logic                        reset_n,
	input  jtagUartPkg::scanCtrl_t      scan,
	output logic                        tdo,
	output logic                        rxPush,
	output logic [`JU_DATA_WIDTH-1:0]   rxByte,
	input  jtagUartPkg::fifoStatus_t    rxStatus,
	output logic                        txPop,
	input  logic [`JU_DATA_WIDTH-1:0]   txHead,
	input  jtagUartPkg::fifoStatus_t    txStatus
);

	localparam int BitIdxWidth = $clog2(`JU_DATA_WIDTH);

	logic [3:0] bitCounter;
	logic [`JU_DATA_WIDTH-1:0] rxShift;
	logic [`JU_COUNT_WIDTH-1:0] captureReg;
	logic [`JU_COUNT_WIDTH-1:0] rxSpace;
	logic byteDone;
	logic isWriteData;
	logic isReadData;

	assign rxSpace = `JU_COUNT_WIDTH'(`JU_FIFO_DEPTH) - rxStatus.count;

	assign isWriteData = scan.ir == jtagUartPkg::irWriteData;
	assign isReadData = scan.ir == jtagUartPkg::irReadData;
	assign byteDone = bitCounter == 4'(`JU_DATA_WIDTH - 1);

	// Last bit comes straight from tdi so the push lands on the 8th sampling edge
	assign rxByte = {scan.tdi, rxShift[`JU_DATA_WIDTH-1:1]};
	assign rxPush = scan.sdr && isWriteData && byteDone;

	// Pop on the edge that ends the 8th bit, next head follows
	assign txPop = scan.sdr && isReadData && byteDone;

	always_comb begin
		tdo = 1'b0;
		case (scan.ir)
			jtagUartPkg::irReadSpace,
			jtagUartPkg::irReadCount: begin
				if (bitCounter < 4'(`JU_COUNT_WIDTH))
					tdo = captureReg[bitCounter];
			end
			jtagUartPkg::irReadData: begin
				tdo = txHead[bitCounter[BitIdxWidth-1:0]];
			end
			default: begin
				tdo = 1'b0;
			end
		endcase
	end

	always_ff @(posedge tck or negedge reset_n) begin
		if (!reset_n) begin
			bitCounter <= '0;
			captureReg <= '0;
		end else if (scan.cdr) begin
			bitCounter <= '0;
			case (scan.ir)
				jtagUartPkg::irReadSpace: captureReg <= rxSpace;
				jtagUartPkg::irReadCount: captureReg <= txStatus.count;
				default:                  captureReg <= captureReg;
			endcase
		end else if (scan.sdr) begin
			case (scan.ir)
				jtagUartPkg::irWriteData,
				jtagUartPkg::irReadData: begin
					// Wrap per byte so bytes stream back to back
					bitCounter <= byteDone ? 4'd0 : bitCounter + 4'd1;
				end
				default: begin
					// Hold at the top, tdo already reads zero past bit 8
					if (bitCounter != 4'hf)
						bitCounter <= bitCounter + 4'd1;
				end
			endcase
		end
	end

	always_ff @(posedge tck) begin
		if (scan.sdr && isWriteData)
			rxShift <= rxByte;
	end

endmodule

// File: source/busRegisterPort.sv
`timescale 1ns/1ps
`include "jtagUart_macros.svh"

module busRegisterPort (
	input  jtagUartPkg::busReq_t        bus,
	output logic [31:0]                 readData,
	output logic                        rxPop,
	input  logic [`JU_DATA_WIDTH-1:0]   rxHead,
	input  jtagUartPkg::fifoStatus_t    rxStatus,
	output logic                        txPush,
	output logic [`JU_DATA_WIDTH-1:0]   txByte,
	input  jtagUartPkg::fifoStatus_t    txStatus
);

	localparam int TopPad = 32 - 16 - `JU_COUNT_WIDTH;
	localparam int MidPad = 15 - `JU_DATA_WIDTH;

	logic [`JU_COUNT_WIDTH-1:0] txSpace;
	logic [31:0] dataWord;
	logic [31:0] spaceWord;

	assign txSpace = `JU_COUNT_WIDTH'(`JU_FIFO_DEPTH) - txStatus.count;

	// Address 0 holds rx count, valid flag and the head byte
	assign dataWord = {
		{TopPad{1'b0}},
		rxStatus.count,
		!rxStatus.empty,
		{MidPad{1'b0}},
		rxHead
	};

	// Address 1 holds tx free space only
	assign spaceWord = {{TopPad{1'b0}}, txSpace, 16'b0};

	assign readData = bus.address ? spaceWord : dataWord;

	// Reading the data register consumes the head byte
	assign rxPop = bus.read && !bus.address;

	// Writes to address 1 have no effect
	assign txPush = bus.write && !bus.address;
	assign txByte = bus.writeData[`JU_DATA_WIDTH-1:0];

endmodule

// File: source/jtagUartBridge.sv
`timescale 1ns/1ps
`include "jtagUart_macros.svh"

module jtagUartBridge (
	input  logic                    tck,
	input  logic                    reset_n,
	input  jtagUartPkg::scanCtrl_t  scan,
	input  jtagUartPkg::busReq_t    bus,
	output logic                    tdo,
	output logic [31:0]             readData
);

	// JTAG to bus direction
	logic rxPush;
	logic rxPop;
	logic [`JU_DATA_WIDTH-1:0] rxByte;
	logic [`JU_DATA_WIDTH-1:0] rxHead;
	jtagUartPkg::fifoStatus_t rxStatus;

	// Bus to JTAG direction
	logic txPush;
	logic txPop;
	logic [`JU_DATA_WIDTH-1:0] txByte;
	logic [`JU_DATA_WIDTH-1:0] txHead;
	jtagUartPkg::fifoStatus_t txStatus;

	jtagDrShifter shifter (
		.tck      (tck),
		.reset_n  (reset_n),
		.scan     (scan),
		.tdo      (tdo),
		.rxPush   (rxPush),
		.rxByte   (rxByte),
		.rxStatus (rxStatus),
		.txPop    (txPop),
		.txHead   (txHead),
		.txStatus (txStatus)
	);

	byteFifo #(.Depth(`JU_FIFO_DEPTH)) rxFifo (
		.tck      (tck),
		.reset_n  (reset_n),
		.push     (rxPush),
		.pushByte (rxByte),
		.pop      (rxPop),
		.headByte (rxHead),
		.status   (rxStatus)
	);

	byteFifo #(.Depth(`JU_FIFO_DEPTH)) txFifo (
		.tck      (tck),
		.reset_n  (reset_n),
		.push     (txPush),
		.pushByte (txByte),
		.pop      (txPop),
		.headByte (txHead),
		.status   (txStatus)
	);

	busRegisterPort regPort (
		.bus      (bus),
		.readData (readData),
		.rxPop    (rxPop),
		.rxHead   (rxHead),
		.rxStatus (rxStatus),
		.txPush   (txPush),
		.txByte   (txByte),
		.txStatus (txStatus)
	);

endmodule

// File: sim/jtagUartBridge_sva.sv
`timescale 1ns/1ps
`include "jtagUart_macros.svh"

module jtagUartBridge_sva (
	input logic                     tck,
	input logic                     reset_n,
	input jtagUartPkg::scanCtrl_t   scan,
	input logic                     tdo,
	input logic                     rxPush,
	input jtagUartPkg::fifoStatus_t rxStatus,
	input jtagUartPkg::fifoStatus_t txStatus
);

	// A scanned byte needs eight sdr cycles
	assert property (@(posedge tck) disable iff (!reset_n) rxPush |=> !rxPush)
		else $error("rxPush high in two consecutive cycles");

	assert property (@(posedge tck) disable iff (!reset_n)
		rxStatus.count <= `JU_COUNT_WIDTH'(`JU_FIFO_DEPTH))
		else $error("rx FIFO count above depth");

	assert property (@(posedge tck) disable iff (!reset_n)
		txStatus.count <= `JU_COUNT_WIDTH'(`JU_FIFO_DEPTH))
		else $error("tx FIFO count above depth");

	assert property (@(posedge tck) disable iff (!reset_n) scan.sdr |-> !$isunknown(tdo))
		else $error("tdo unknown during sdr");

	assert property (@(posedge tck) $rose(reset_n) |-> rxStatus.empty && txStatus.empty)
		else $error("FIFOs not empty after reset");

endmodule

bind jtagUartBridge jtagUartBridge_sva bridgeChecks (
	.tck      (tck),
	.reset_n  (reset_n),
	.scan     (scan),
	.tdo      (tdo),
	.rxPush   (rxPush),
	.rxStatus (rxStatus),
	.txStatus (txStatus)
);

// File: sim/jtagUartBridge_tb.sv
`timescale 1ns/1ps
`include "jtagUart_macros.svh"

module jtagUartBridge_tb;

	localparam int ResetCycles = 16;
	localparam int CyclesPerLine = 16;
	localparam int TimeoutMargin = 100;
	localparam logic [31:0] LfsrSeed = 32'hc204a428;
	localparam logic [31:0] LfsrTaps = 32'h80200003;

	logic tck;
	logic reset_n;
	jtagUartPkg::scanCtrl_t scan;
	jtagUartPkg::busReq_t bus;
	logic tdo;
	logic [31:0] readData;

	logic [31:0] lfsr;
	logic [7:0] opQueue[$];
	logic [31:0] valueQueue[$];
	int checkCount = 0;
	int mismatchCount = 0;
	int formatErrors = 0;
	int lineCount = 0;
	int cycleLimit = 0;
	int cycleCount = 0;
	bit loaded = 1'b0;

	jtagUartBridge jtagUartBridge_inst (
		.tck      (tck),
		.reset_n  (reset_n),
		.scan     (scan),
		.bus      (bus),
		.tdo      (tdo),
		.readData (readData)
	);

	initial begin
		tck = 1'b0;
		forever #50 tck = ~tck;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ LfsrTaps;
		return next;
	endfunction

	function automatic jtagUartPkg::scanCtrl_t makeScan(input logic sdr, input logic cdr,
			input jtagUartPkg::irCode_e ir, input logic tdi);
		jtagUartPkg::scanCtrl_t s;
		s.sdr = sdr;
		s.cdr = cdr;
		s.ir = ir;
		s.tdi = tdi;
		return s;
	endfunction

	function automatic jtagUartPkg::busReq_t makeBus(input logic read, input logic write,
			input logic address, input logic [31:0] writeData);
		jtagUartPkg::busReq_t b;
		b.read = read;
		b.write = write;
		b.address = address;
		b.writeData = writeData;
		return b;
	endfunction

	task automatic reportMismatch(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		mismatchCount++;
		$display("Fail %0t: %s read %h, expected %h", $time, what, got, expected);
	endtask

	// Idle gap of 0 to 3 cycles, two LFSR bits
	task automatic waitRandomGap();
		int gap;
		gap = 0;
		repeat (2) begin
			gap = gap * 2 + int'(lfsr[0]);
			lfsr = lfsrNext(lfsr);
		end
		repeat (gap) @(posedge tck);
	endtask

	task automatic shiftByteIn(input logic [7:0] value);
		logic [7:0] pending;
		pending = value;
		@(posedge tck);
		scan <= makeScan(1'b0, 1'b1, jtagUartPkg::irWriteData, 1'b0);
		repeat (`JU_DATA_WIDTH) begin
			@(posedge tck);
			scan <= makeScan(1'b1, 1'b0, jtagUartPkg::irWriteData, pending[0]);
			pending = pending >> 1;
		end
		@(posedge tck);
		scan <= makeScan(1'b0, 1'b0, jtagUartPkg::irWriteData, 1'b0);
	endtask

	// Capture, then shift nBits out LSB first, sampling tdo mid-cycle
	task automatic captureAndShiftOut(input jtagUartPkg::irCode_e ir, input int nBits,
			output logic [8:0] got);
		got = '0;
		@(posedge tck);
		scan <= makeScan(1'b0, 1'b1, ir, 1'b0);
		for (int i = 0; i < nBits; i++) begin
			@(posedge tck);
			scan <= makeScan(1'b1, 1'b0, ir, 1'b0);
			@(negedge tck);
			got = got | (9'(tdo) << i);
		end
		@(posedge tck);
		scan <= makeScan(1'b0, 1'b0, ir, 1'b0);
	endtask

	task automatic writeRegister(input logic [7:0] value);
		@(posedge tck);
		bus <= makeBus(1'b0, 1'b1, 1'b0, {24'b0, value});
		@(posedge tck);
		bus <= makeBus(1'b0, 1'b0, 1'b0, 32'b0);
	endtask

	task automatic readRegister(input logic address, output logic [31:0] got);
		@(posedge tck);
		bus <= makeBus(1'b1, 1'b0, address, 32'b0);
		@(negedge tck);
		got = readData;
		@(posedge tck);
		bus <= makeBus(1'b0, 1'b0, 1'b0, 32'b0);
	endtask

	task automatic runOperation(input logic [7:0] op, input logic [31:0] value);
		logic [8:0] bits;
		logic [31:0] word;
		case (op)
			"S": shiftByteIn(value[7:0]);
			"W": writeRegister(value[7:0]);
			"J": begin
				captureAndShiftOut(jtagUartPkg::irReadData, `JU_DATA_WIDTH, bits);
				checkCount++;
				if (bits[7:0] !== value[7:0])
					reportMismatch("tx byte on tdo", {24'b0, bits[7:0]}, {24'b0, value[7:0]});
			end
			"P", "K": begin
				if (op == "P")
					captureAndShiftOut(jtagUartPkg::irReadSpace, `JU_COUNT_WIDTH, bits);
				else
					captureAndShiftOut(jtagUartPkg::irReadCount, `JU_COUNT_WIDTH, bits);
				checkCount++;
				if (bits !== value[8:0])
					reportMismatch("captured count on tdo", {23'b0, bits}, {23'b0, value[8:0]});
			end
			"R", "F": begin
				readRegister(op == "F", word);
				checkCount++;
				if (word !== value)
					reportMismatch("bus register word", word, value);
			end
			default: begin
				formatErrors++;
				$display("Unknown operation code %c in the stimulus file", op);
			end
		endcase
	endtask

	task automatic loadStimulus(output bit ok);
		int fd;
		int fields;
		string line;
		logic [7:0] op;
		logic [31:0] value;
		ok = 1'b0;
		fd = $fopen("sim/jtagUart_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file sim/jtagUart_stimulus.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				lineCount++;
				if (line.len() < 3 || line.getc(0) == "#")
					continue;
				fields = $sscanf(line, "%c %h", op, value);
				if (fields != 2) begin
					formatErrors++;
					$display("Stimulus line %0d could not be parsed", lineCount);
				end else begin
					opQueue.push_back(op);
					valueQueue.push_back(value);
				end
			end
			$fclose(fd);
			ok = 1'b1;
		end
	endtask

	initial begin
		bit ok;
		reset_n = 1'b0;
		scan = makeScan(1'b0, 1'b0, jtagUartPkg::irWriteData, 1'b0);
		bus = makeBus(1'b0, 1'b0, 1'b0, 32'b0);
		lfsr = LfsrSeed;
		loadStimulus(ok);
		if (!ok) begin
			$display("sim failed");
			$finish;
		end else begin
			cycleLimit = ResetCycles + CyclesPerLine * lineCount + TimeoutMargin;
			loaded = 1'b1;
			repeat (ResetCycles) @(posedge tck);
			reset_n <= 1'b1;
			@(posedge tck);
			foreach (opQueue[i]) begin
				runOperation(opQueue[i], valueQueue[i]);
				waitRandomGap();
			end
			repeat (2) @(posedge tck);
			$display("%0d checks, %0d mismatches, %0d stimulus errors",
				checkCount, mismatchCount, formatErrors);
			if (mismatchCount == 0 && formatErrors == 0 && checkCount > 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
			$finish;
		end
	end

	initial begin
		wait (loaded);
		while (cycleCount < cycleLimit) begin
			@(posedge tck);
			cycleCount++;
		end
		$display("Timeout, the run did not finish within %0d cycles", cycleLimit);
		$display("sim failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+source
source/jtagUartPkg.sv
source/byteFifo.sv
source/jtagDrShifter.sv
source/busRegisterPort.sv
source/jtagUartBridge.sv
sim/jtagUartBridge_sva.sv
sim/jtagUartBridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module jtagUartBridge_tb \
	-f vlog.f \
	-o jtagUartBridge_sim

output="$(./obj_dir/jtagUartBridge_sim 2>&1 || true)"
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
	exit 0
fi
exit 1

// File: sim/jtagUart_stimulus.txt
# op value: S scan byte in, J expect tx byte, P expect rx space, K expect tx count
# W bus write byte, R expect word at address 0, F expect word at address 1
R 00000000
F 01000000
K 000
P 100
S 41
S 5a
S c3
P 0fd
R 00038041
R 0002805a
R 000180c3
R 00000000
P 100
W 11
W 22
W 33
K 003
F 00fd0000
J 11
J 22
F 00ff0000
J 33
K 000
J 00
K 000
S 7e
W a5
S 81
R 0002807e
J a5
W 3c
P 0ff
K 001
R 00018081
J 3c
R 00000000
K 000
F 01000000
